// File: bench/eboxTb.sv
module eboxTb;
  timeunit 1ns;
  timeprecision 1ns;
  import eboxPkg::*;

  localparam int FM_ADDR_BITS = 4;
  localparam int NUM_CMDS = 400;
  localparam int CYCLES_PER_CMD = 45;
  localparam int RESET_CYCLES = 4;
  localparam int ALU_LATENCY = 2;
  // Two setup edges, 36 steps, one write-back edge
  localparam int MUL_LATENCY = 39;
  localparam logic [35:0] ONES = '1;

  logic CLK;
  logic FPGA_RESET;
  logic cmdValid;
  logic cmdReady;
  tOp cmdOp;
  logic [FM_ADDR_BITS-1:0] cmdAc;
  tWord cmdData;
  logic resValid;
  logic resReady;
  tWord resWord;
  tWord resMq;
  logic resCarry;

  // Reference model and expected results in arrival order
  logic [35:0] accModel [1 << FM_ADDR_BITS];
  logic [35:0] expWordQ [$];
  logic [35:0] expMqQ [$];
  logic expCarryQ [$];
  logic expMulQ [$];
  int acceptQ [$];

  logic [31:0] lcgState;
  int errorCount = 0;
  int checkCount = 0;
  int sampleCycle = 0;
  int resultCount = 0;
  int nextIndex = 0;
  int stallCycles = 0;
  int cycleCount = 0;
  logic cmdTaken = 1'b0;
  logic resTakenLast = 1'b0;
  logic heldValid = 1'b0;
  logic [35:0] heldWord;
  logic [35:0] heldMq;
  logic heldCarry;
  logic [FM_ADDR_BITS-1:0] pairAc = '0;

  eboxTop #(
    .FM_ADDR_BITS(FM_ADDR_BITS)
  ) UUT (
    .CLK       (CLK),
    .FPGA_RESET(FPGA_RESET),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .cmdOp     (cmdOp),
    .cmdAc     (cmdAc),
    .cmdData   (cmdData),
    .resValid  (resValid),
    .resReady  (resReady),
    .resWord   (resWord),
    .resMq     (resMq),
    .resCarry  (resCarry)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [35:0] randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRandom();
    lo = nextRandom();
    return {hi[31:14], lo[31:14]};
  endfunction

  // Corner operands for the carry chain and the multiplier
  function automatic logic [35:0] edgeWord();
    logic [31:0] r;
    r = nextRandom();
    case (r[31:29])
      3'd0: return '0;
      3'd1: return ONES;
      3'd2: return 36'd1;
      3'd3: return 36'h800000000;
      3'd4: return 36'h7ffffffff;
      default: return randomWord();
    endcase
  endfunction

  task automatic compareValue(input logic ok, input string msg);
    checkCount++;
    assert (ok) else begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic checkProtocol(input logic ok, input string msg);
    checkCount++;
    assert (ok) else begin
      errorCount++;
      $display("ERROR at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic finishRun();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // Reads of every accumulator, move/read pairs, carry corners, then a random mix
  task automatic presentCommand(input int idx);
    logic [31:0] r;
    tOp op;
    logic [FM_ADDR_BITS-1:0] ac;
    logic [35:0] d;
    r = nextRandom();
    ac = r[31:28];
    d = randomWord();
    op = opRead;
    if (idx < 16) begin
      ac = idx[3:0];
    end else if (idx < 64) begin
      op = idx[0] ? opRead : opMove;
      // Every other read returns the word that was just moved
      if (idx[0] == 1'b0) begin
        pairAc = ac;
      end else if (idx[1] == 1'b0) begin
        ac = pairAc;
      end
    end else if (idx < 72) begin
      ac = 4'd5;
      case (idx - 64)
        0: begin
          op = opMove;
          d = ONES;
        end
        1: begin
          op = opAdd;
          d = 36'd1;
        end
        2: begin
          op = opSub;
          d = 36'd1;
        end
        3: begin
          op = opAdd;
          d = ONES;
        end
        4: begin
          op = opSub;
          d = '0;
        end
        5: begin
          op = opMul;
          d = ONES;
        end
        6: begin
          op = opMove;
          d = ONES;
        end
        default: begin
          op = opMul;
          d = ONES;
        end
      endcase
    end else begin
      op = tOp'(3'(r[23:16] % 8'd7));
      if (r[13:12] == 2'b00) begin
        d = edgeWord();
      end
    end
    cmdValid <= 1'b1;
    cmdOp <= op;
    cmdAc <= ac;
    cmdData <= d;
  endtask

  // Model update on the command handshake
  task automatic acceptCommand();
    logic [35:0] acc;
    logic [35:0] d;
    logic [35:0] word;
    logic [35:0] mq;
    logic carry;
    logic [71:0] product;
    acc = accModel[cmdAc];
    d = cmdData;
    word = acc;
    mq = '0;
    carry = 1'b0;
    product = '0;
    case (cmdOp)
      opMove: word = d;
      opRead: word = acc;
      opAdd: {carry, word} = {1'b0, acc} + {1'b0, d};
      opSub: begin
        word = acc - d;
        // Carry out means no borrow
        carry = (acc >= d);
      end
      opAnd: word = acc & d;
      opXor: word = acc ^ d;
      default: begin
        product = {36'd0, acc} * {36'd0, d};
        word = product[71:36];
        mq = product[35:0];
      end
    endcase
    if (cmdOp != opRead) begin
      accModel[cmdAc] = word;
    end
    expWordQ.push_back(word);
    expMqQ.push_back(mq);
    expCarryQ.push_back(carry);
    expMulQ.push_back(cmdOp == opMul);
    acceptQ.push_back(sampleCycle);
  endtask

  // Sampled mid-cycle where every DUT input and output is settled
  task automatic sampleOutputs();
    int latency;
    int expLatency;
    logic resTaken;
    cmdTaken = cmdValid && cmdReady;
    resTaken = resValid && resReady;
    if (resValid && !resReady) begin
      stallCycles++;
    end
    checkProtocol(!(cmdReady && expWordQ.size() != 0),
                  "cmdReady high while a result is still owed");
    if (resTakenLast) begin
      checkProtocol(cmdReady, "cmdReady did not return the cycle after a result was taken");
    end
    if (resValid) begin
      if (expWordQ.size() == 0) begin
        checkProtocol(1'b0, "resValid high with no command outstanding");
      end else if (!heldValid) begin
        heldValid = 1'b1;
        heldWord = resWord;
        heldMq = resMq;
        heldCarry = resCarry;
        // The accept edge comes one sample after its recorded cycle
        latency = sampleCycle - acceptQ[0] - 1;
        expLatency = expMulQ[0] ? MUL_LATENCY : ALU_LATENCY;
        compareValue(latency == expLatency,
                     $sformatf("latency %0d cycles, expected %0d", latency, expLatency));
      end else begin
        compareValue(resWord == heldWord && resMq == heldMq && resCarry == heldCarry,
                     "result changed while waiting for resReady");
      end
    end
    if (resTaken && expWordQ.size() != 0) begin
      compareValue(resWord == expWordQ[0],
                   $sformatf("resWord %h, expected %h", resWord, expWordQ[0]));
      compareValue(resCarry == expCarryQ[0],
                   $sformatf("resCarry %b, expected %b", resCarry, expCarryQ[0]));
      if (expMulQ[0]) begin
        compareValue(resMq == expMqQ[0],
                     $sformatf("resMq %h, expected %h", resMq, expMqQ[0]));
      end
      void'(expWordQ.pop_front());
      void'(expMqQ.pop_front());
      void'(expCarryQ.pop_front());
      void'(expMulQ.pop_front());
      void'(acceptQ.pop_front());
      heldValid = 1'b0;
      resultCount++;
    end
    resTakenLast = resTaken;
    if (cmdTaken) begin
      acceptCommand();
    end
  endtask

  task automatic driveInputs();
    logic [31:0] r;
    r = nextRandom();
    if (cmdTaken || !cmdValid) begin
      if (nextIndex < NUM_CMDS && r[31:29] != 3'd0) begin
        presentCommand(nextIndex);
        nextIndex++;
      end else begin
        cmdValid <= 1'b0;
      end
    end
    // Heavy back-pressure over the middle stretch of results
    if (resultCount >= 150 && resultCount < 250) begin
      resReady <= (r[7:6] == 2'b00);
    end else begin
      resReady <= (r[7:6] != 2'b00);
    end
  endtask

  initial begin
    CLK = 1'b0;
    FPGA_RESET = 1'b1;
    cmdValid = 1'b0;
    cmdOp = opMove;
    cmdAc = '0;
    cmdData = '0;
    resReady = 1'b0;
    lcgState = 32'h22d4e06d;
    for (int i = 0; i < (1 << FM_ADDR_BITS); i++) begin
      accModel[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    FPGA_RESET <= 1'b0;
    @(negedge CLK);
    checkProtocol(cmdReady && !resValid, "port state after reset is wrong");
    while (resultCount < NUM_CMDS) begin
      @(posedge CLK);
      driveInputs();
      @(negedge CLK);
      sampleCycle++;
      sampleOutputs();
    end
    // Nothing more may come out once every command is answered
    repeat (4) begin
      @(negedge CLK);
      checkProtocol(!resValid, "extra result after the last command");
    end
    checkProtocol(expWordQ.size() == 0, "results still owed at the end of the run");
    finishRun();
  end

  // Watchdog budget grows with every cycle spent under back-pressure
  initial begin
    while (cycleCount <= RESET_CYCLES + NUM_CMDS * CYCLES_PER_CMD + stallCycles) begin
      @(posedge CLK);
      cycleCount++;
    end
    $display("ERROR: timeout after %0d cycles, the run did not finish", cycleCount);
    errorCount++;
    finishRun();
  end

endmodule

// File: design/adder36.sv
module adder36 (
  input  eboxPkg::tWord    a,
  input  eboxPkg::tWord    b,
  input  eboxPkg::tAluFunc func,
  output eboxPkg::tWord    sum,
  output logic             carryOut
);
  import eboxPkg::*;

  localparam int GROUP_BITS = 6;
  localparam int GROUPS = WORD_BITS / GROUP_BITS;

  tWord bIn;
  tWord gen;
  tWord prop;
  tWord arith;
  logic carryIn;
  logic [0:GROUPS-1] groupGen;
  logic [0:GROUPS-1] groupProp;
  // groupCarry[k] is the carry out of group k, the last entry is the carry in
  logic [0:GROUPS] groupCarry;

  // Subtract as a + ~b + 1
  assign carryIn = (func == aluSub);
  assign bIn = (func == aluSub) ? ~b : b;
  assign gen = a & bIn;
  assign prop = a ^ bIn;

  // Generate and propagate per 6-bit group, low bit of group k is 6k+5
  always_comb begin
    logic g;
    for (int k = 0; k < GROUPS; k++) begin
      g = 1'b0;
      for (int i = GROUP_BITS - 1; i >= 0; i--) begin
        g = gen[k*GROUP_BITS + i] | (prop[k*GROUP_BITS + i] & g);
      end
      groupGen[k] = g;
      groupProp[k] = &prop[k*GROUP_BITS +: GROUP_BITS];
    end
  end

  // Look-ahead across groups, each carry in flat sum-of-products form
  always_comb begin
    logic chain;
    logic term;
    groupCarry[GROUPS] = carryIn;
    for (int k = 0; k < GROUPS; k++) begin
      chain = 1'b1;
      term = 1'b0;
      for (int j = k; j < GROUPS; j++) begin
        term = term | (chain & groupGen[j]);
        chain = chain & groupProp[j];
      end
      groupCarry[k] = term | (chain & carryIn);
    end
  end

  // Ripple inside each group from its look-ahead carry
  always_comb begin
    logic c;
    for (int k = 0; k < GROUPS; k++) begin
      c = groupCarry[k + 1];
      for (int i = GROUP_BITS - 1; i >= 0; i--) begin
        arith[k*GROUP_BITS + i] = prop[k*GROUP_BITS + i] ^ c;
        c = gen[k*GROUP_BITS + i] | (prop[k*GROUP_BITS + i] & c);
      end
    end
  end

  always_comb begin
    unique case (func)
      aluAnd: begin
        sum = a & b;
        carryOut = 1'b0;
      end
      aluXor: begin
        sum = a ^ b;
        carryOut = 1'b0;
      end
      default: begin
        sum = arith;
        carryOut = groupCarry[0];
      end
    endcase
  end

endmodule

// File: design/dataPath.sv
module dataPath (
  input  logic             CLK,
  input  logic             FPGA_RESET,
  input  eboxPkg::tWord    operand,
  input  eboxPkg::tWord    fmData,
  input  eboxPkg::tArSel   arSel,
  input  eboxPkg::tAluFunc aluFunc,
  input  logic             brLoad,
  input  logic             mqLoad,
  input  logic             mulStep,
  output eboxPkg::tWord    ar,
  output eboxPkg::tWord    mq,
  output logic             carry
);
  import eboxPkg::*;

  tWord br;
  tWord ada;
  tWord adb;
  tWord sum;
  tWord stepWord;
  logic adderCarry;
  logic stepCarry;

  // The operand waits in AR until the execute edge, so outside multiply
  // the adder sees BR op AR. Multiply accumulates BR into AR.
  assign ada = mulStep ? ar : br;
  assign adb = mulStep ? br : ar;

  adder36 adder (
    .a       (ada),
    .b       (adb),
    .func    (aluFunc),
    .sum     (sum),
    .carryOut(adderCarry)
  );

  // Multiplier bit picks partial sum or plain AR
  assign stepWord = mq[WORD_BITS-1] ? sum : ar;
  assign stepCarry = mq[WORD_BITS-1] & adderCarry;

  // AR and carry
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      ar <= '0;
      carry <= 1'b0;
    end else if (mulStep) begin
      // Right shift of {carry, sum}, bit 35 falls into MQ
      ar <= {stepCarry, stepWord[0:WORD_BITS-2]};
      carry <= 1'b0;
    end else begin
      unique case (arSel)
        arOperand: begin
          ar <= operand;
          carry <= 1'b0;
        end
        arAdder: begin
          ar <= sum;
          carry <= adderCarry;
        end
        arClear: begin
          ar <= '0;
          carry <= 1'b0;
        end
        default: begin
          ar <= ar;
        end
      endcase
    end
  end

  // BR takes the accumulator
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      br <= '0;
    end else if (brLoad) begin
      br <= fmData;
    end
  end

  // MQ holds the multiplier and collects the low product bits
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      mq <= '0;
    end else if (mulStep) begin
      mq <= {stepWord[WORD_BITS-1], mq[0:WORD_BITS-2]};
    end else if (mqLoad) begin
      mq <= operand;
    end
  end

endmodule

// File: design/eboxPkg.sv
package eboxPkg;

  // Data word, numbered [0:35] with bit 0 as the most significant
  localparam int WORD_BITS = 36;

  // Shift-and-add iterations for an unsigned multiply
  localparam int MUL_STEPS = 36;

  typedef logic [0:WORD_BITS-1] tWord;

  // Command operation codes, code 3'b111 is unused
  typedef enum logic [2:0] {
    opMove = 3'd0,
    opRead = 3'd1,
    opAdd  = 3'd2,
    opSub  = 3'd3,
    opAnd  = 3'd4,
    opXor  = 3'd5,
    opMul  = 3'd6
  } tOp;

  // Adder/boolean unit function
  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluAnd = 2'd2,
    aluXor = 2'd3
  } tAluFunc;

  // AR input mux
  typedef enum logic [1:0] {
    arHold    = 2'd0,
    arOperand = 2'd1,
    arAdder   = 2'd2,
    arClear   = 2'd3
  } tArSel;

endpackage

// File: design/eboxSequencer.sv
module eboxSequencer #(
  parameter int FM_ADDR_BITS = 4
) (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    cmdValid,
  input  eboxPkg::tOp             cmdOp,
  input  logic [FM_ADDR_BITS-1:0] cmdAc,
  input  logic                    resReady,
  input  logic                    countDone,
  output logic                    cmdReady,
  output logic                    resValid,
  output logic                    fmWrite,
  output logic [FM_ADDR_BITS-1:0] fmAddr,
  output logic                    brLoad,
  output logic                    mqLoad,
  output logic                    mulStep,
  output logic                    countStart,
  output eboxPkg::tAluFunc        aluFunc,
  output eboxPkg::tArSel          arSel
);
  import eboxPkg::*;

  typedef enum logic [2:0] {
    stIdle,
    stFetch,
    stExecute,
    stMulStep,
    stWriteBack,
    stDone
  } tState;

  tState state;
  tState nextState;
  tOp curOp;
  logic writesAc;

  // Operation and address held for the whole command
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      state <= stIdle;
      curOp <= opMove;
      fmAddr <= '0;
    end else begin
      state <= nextState;
      if (cmdValid && cmdReady) begin
        curOp <= cmdOp;
        fmAddr <= cmdAc;
      end
    end
  end

  // Read and unused codes leave the accumulator alone
  always_comb begin
    case (curOp)
      opMove, opAdd, opSub, opAnd, opXor, opMul: writesAc = 1'b1;
      default: writesAc = 1'b0;
    endcase
  end

  always_comb begin
    nextState = state;
    cmdReady = 1'b0;
    resValid = 1'b0;
    fmWrite = 1'b0;
    brLoad = 1'b0;
    mqLoad = 1'b0;
    mulStep = 1'b0;
    countStart = 1'b0;
    aluFunc = aluAdd;
    arSel = arHold;
    unique case (state)
      stIdle: begin
        cmdReady = 1'b1;
        // Operand parks in AR and MQ on acceptance
        if (cmdValid) begin
          arSel = arOperand;
          mqLoad = 1'b1;
          nextState = stFetch;
        end
      end
      stFetch: begin
        brLoad = 1'b1;
        // Read passes BR through the adder with a zero AR
        if (!writesAc) begin
          arSel = arClear;
        end
        nextState = stExecute;
      end
      stExecute: begin
        nextState = stWriteBack;
        case (curOp)
          opMove: arSel = arHold;
          opMul: begin
            arSel = arClear;
            countStart = 1'b1;
            nextState = stMulStep;
          end
          opSub: begin
            arSel = arAdder;
            aluFunc = aluSub;
          end
          opAnd: begin
            arSel = arAdder;
            aluFunc = aluAnd;
          end
          opXor: begin
            arSel = arAdder;
            aluFunc = aluXor;
          end
          default: arSel = arAdder;
        endcase
      end
      stMulStep: begin
        mulStep = 1'b1;
        if (countDone) begin
          nextState = stWriteBack;
        end
      end
      stWriteBack: begin
        fmWrite = writesAc;
        if (curOp == opMul) begin
          nextState = stDone;
        end else begin
          resValid = 1'b1;
          nextState = resReady ? stIdle : stDone;
        end
      end
      stDone: begin
        resValid = 1'b1;
        if (resReady) begin
          nextState = stIdle;
        end
      end
      default: nextState = stIdle;
    endcase
  end

  resHeld: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    resValid && !resReady |=> resValid)
    else $error("result withdrawn before handshake");

  readyAfterResult: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    $rose(cmdReady) |-> $past(resValid && resReady))
    else $error("command port reopened before the result was taken");

endmodule

// File: design/eboxTop.sv
module eboxTop #(
  parameter int FM_ADDR_BITS = 4
) (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    cmdValid,
  output logic                    cmdReady,
  input  eboxPkg::tOp             cmdOp,
  input  logic [FM_ADDR_BITS-1:0] cmdAc,
  input  eboxPkg::tWord           cmdData,
  output logic                    resValid,
  input  logic                    resReady,
  output eboxPkg::tWord           resWord,
  output eboxPkg::tWord           resMq,
  output logic                    resCarry
);
  import eboxPkg::*;

  logic fmWrite;
  logic [FM_ADDR_BITS-1:0] fmAddr;
  logic brLoad;
  logic mqLoad;
  logic mulStep;
  logic countStart;
  logic countDone;
  tAluFunc aluFunc;
  tArSel arSel;
  tWord fmData;

  eboxSequencer #(
    .FM_ADDR_BITS(FM_ADDR_BITS)
  ) sequencer (
    .CLK       (CLK),
    .FPGA_RESET(FPGA_RESET),
    .cmdValid  (cmdValid),
    .cmdOp     (cmdOp),
    .cmdAc     (cmdAc),
    .resReady  (resReady),
    .countDone (countDone),
    .cmdReady  (cmdReady),
    .resValid  (resValid),
    .fmWrite   (fmWrite),
    .fmAddr    (fmAddr),
    .brLoad    (brLoad),
    .mqLoad    (mqLoad),
    .mulStep   (mulStep),
    .countStart(countStart),
    .aluFunc   (aluFunc),
    .arSel     (arSel)
  );

  stepCounter counter (
    .CLK       (CLK),
    .FPGA_RESET(FPGA_RESET),
    .countStart(countStart),
    .countDone (countDone)
  );

  // AR is the write-back source
  fastMemory #(
    .FM_ADDR_BITS(FM_ADDR_BITS)
  ) fm (
    .CLK       (CLK),
    .FPGA_RESET(FPGA_RESET),
    .write     (fmWrite),
    .addr      (fmAddr),
    .writeData (resWord),
    .readData  (fmData)
  );

  dataPath edp (
    .CLK       (CLK),
    .FPGA_RESET(FPGA_RESET),
    .operand   (cmdData),
    .fmData    (fmData),
    .arSel     (arSel),
    .aluFunc   (aluFunc),
    .brLoad    (brLoad),
    .mqLoad    (mqLoad),
    .mulStep   (mulStep),
    .ar        (resWord),
    .mq        (resMq),
    .carry     (resCarry)
  );

endmodule

// File: design/fastMemory.sv
module fastMemory #(
  parameter int FM_ADDR_BITS = 4
) (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    write,
  input  logic [FM_ADDR_BITS-1:0] addr,
  input  eboxPkg::tWord           writeData,
  output eboxPkg::tWord           readData
);
  import eboxPkg::*;

  localparam int FM_WORDS = 1 << FM_ADDR_BITS;

  // Accumulator block
  tWord mem [FM_WORDS];

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      for (int i = 0; i < FM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (write) begin
      mem[addr] <= writeData;
    end
  end

  // Read is asynchronous, BR samples it on the fetch edge
  assign readData = mem[addr];

endmodule

// File: design/stepCounter.sv
module stepCounter (
  input  logic CLK,
  input  logic FPGA_RESET,
  input  logic countStart,
  output logic countDone
);
  import eboxPkg::*;

  localparam int COUNT_BITS = $clog2(MUL_STEPS + 1);

  logic [COUNT_BITS-1:0] count;

  // Counts down to zero and parks there until the next multiply
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      count <= '0;
    end else if (countStart) begin
      count <= COUNT_BITS'(MUL_STEPS);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Last step is in progress
  assign countDone = (count == COUNT_BITS'(1));

  noRestart: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    countStart |-> count == '0)
    else $error("multiply step count restarted while still running");

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module eboxTb -f verilog.f -o eboxSim

if ! ./obj_dir/eboxSim > sim.log 2>&1; then
  cat sim.log
  echo "Simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: verilog.f
design/eboxPkg.sv
design/stepCounter.sv
design/fastMemory.sv
design/adder36.sv
design/dataPath.sv
design/eboxSequencer.sv
design/eboxTop.sv
bench/eboxTb.sv
